// ==== ice_app_top.f ====
common/ice_msg_pkg.sv
afifo/afifo.sv
design/sample_producer.sv
spi_engine/spi_msg_engine.sv
design/spi_pin_regs.sv
design/ice_app_top.sv
verification/ice_app_top_sva.sv
verification/ice_app_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ice_app_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module ice_app_top_tb \
        -f ice_app_top.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vice_app_top_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

// ==== verification/ice_app_top_tb.sv ====
module ice_app_top_tb;

    localparam int NUM_TX         = 11;
    localparam int TIMEOUT_CYCLES = NUM_TX * 700;
    localparam int KIND_NONE      = 0;
    localparam int KIND_RESP      = 1;
    localparam int KIND_READ      = 2;

    logic       ice_st_spi_clk = 1'b0;
    logic       prod_clk       = 1'b0;
    logic       spi_cs         = 1'b0;
    logic [7:0] d_in           = 8'h00;
    logic [7:0] d_out;
    logic       d_oe;
    logic       d_ready;
    logic [3:0] led;

    // Host pin values for the next rising edge
    logic       cs_drv  = 1'b0;
    logic [7:0] din_drv = 8'h00;

    logic [31:0] rng_state = 32'h5f0f454f;
    int          errors    = 0;
    int          cycle_cnt = 0;
    int          tx_cnt    = 0;

    // ==================================================
    // Transaction table
    // ==================================================
    string       tx_name [NUM_TX];
    logic [7:0]  tx_type [NUM_TX];
    logic [23:0] tx_arg  [NUM_TX];
    logic [3:0]  tx_led  [NUM_TX];
    logic [31:0] tx_resp [NUM_TX];

    // Bus values seen while d_oe is high
    logic [7:0] samples [ice_msg_pkg::CHUNK_LEN];

    always #50 ice_st_spi_clk = ~ice_st_spi_clk;
    always #15 prod_clk = ~prod_clk;

    always @(posedge ice_st_spi_clk) begin
        spi_cs <= cs_drv;
        d_in   <= din_drv;
    end

    ice_app_top u_ice_app_top (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .prod_clk       (prod_clk),
        .d_in           (d_in),
        .d_out          (d_out),
        .d_oe           (d_oe),
        .d_ready        (d_ready),
        .led            (led)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // The FPGA always sees type bit 7 as set
    function automatic int tx_kind(input logic [7:0] t);
        logic [7:0] eff;
        int         kind;
        eff = t | 8'h80;
        if (eff == ice_msg_pkg::MSG_TYPE_READOUT) begin
            kind = KIND_READ;
        end else if (eff[ice_msg_pkg::MSG_TYPE_RESP_BIT]) begin
            kind = KIND_RESP;
        end else begin
            kind = KIND_NONE;
        end
        return kind;
    endfunction

    // Two bus clocks hold one byte pair, high nibbles first
    function automatic logic [15:0] pair_from_nibbles(input logic [7:0] hi, input logic [7:0] lo);
        return {hi[7:4], lo[7:4], hi[3:0], lo[3:0]};
    endfunction

    task automatic step_rand();
        rng_state = xorshift32(rng_state);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("** Error: %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_tx(input string name, input logic [7:0] t, input logic [23:0] arg,
                          input logic [3:0] exp_led);
        tx_name[tx_cnt] = name;
        tx_type[tx_cnt] = t;
        tx_arg[tx_cnt]  = arg;
        tx_led[tx_cnt]  = exp_led;
        // Echo answers with the argument on top of a zero byte
        tx_resp[tx_cnt] = {arg, 8'h00};
        tx_cnt++;
    endtask

    // ==================================================
    // Host model, one transaction per spi_cs window
    // ==================================================
    task automatic run_tx(input int idx);
        logic [31:0] msg;
        logic        fell;
        logic        seen_ready;
        logic        done;
        int          kind;
        int          k;
        int          p;
        int          wait_cnt;
        int          nib_cnt;
        int          gap;
        msg        = {tx_type[idx], tx_arg[idx]};
        kind       = tx_kind(tx_type[idx]);
        fell       = 1'b0;
        seen_ready = 1'b0;
        done       = 1'b0;
        wait_cnt   = 0;
        nib_cnt    = 0;

        // Dummy byte first, then the message MSB first
        for (k = 0; k < ice_msg_pkg::MSG_CYCLES; k++) begin
            @(negedge ice_st_spi_clk);
            check({tx_name[idx], " d_oe during input"}, 32'd0, 32'(d_oe));
            cs_drv = 1'b1;
            if (k < 2) begin
                din_drv = 8'h00;
            end else begin
                din_drv = {4'h0, msg[31 - 4 * (k - 2) -: 4]};
            end
        end

        while (!done) begin
            @(negedge ice_st_spi_clk);
            din_drv = 8'h00;
            wait_cnt++;
            if (d_ready) begin
                seen_ready = 1'b1;
            end
            if (d_oe) begin
                if (nib_cnt < ice_msg_pkg::CHUNK_LEN) begin
                    samples[nib_cnt] = d_out;
                end
                nib_cnt++;
            end else if (nib_cnt != 0) begin
                fell = 1'b1;
            end
            case (kind)
                KIND_NONE: done = (wait_cnt >= 6);
                KIND_RESP: done = fell || (nib_cnt >= 6);
                default:   done = fell;
            endcase
        end

        case (kind)
            KIND_NONE: check({tx_name[idx], " d_oe cycles"}, 32'd0, 32'(nib_cnt));
            KIND_RESP: begin
                // Bus stays driven past the 4 response cycles
                check({tx_name[idx], " d_oe cycles"}, 32'd6, 32'(nib_cnt));
                check({tx_name[idx], " response"}, tx_resp[idx],
                      {pair_from_nibbles(samples[0], samples[1]),
                       pair_from_nibbles(samples[2], samples[3])});
            end
            default: begin
                check({tx_name[idx], " d_ready seen"}, 32'd1, 32'(seen_ready));
                check({tx_name[idx], " d_oe cycles"}, 32'(ice_msg_pkg::CHUNK_LEN),
                      32'(nib_cnt));
                // Bursts count down from 8'hFF, one byte per bus clock
                for (p = 0; p < ice_msg_pkg::CHUNK_LEN / 2; p++) begin
                    check({tx_name[idx], " chunk pair"},
                          32'({8'(255 - 2 * p), 8'(254 - 2 * p)}),
                          32'(pair_from_nibbles(samples[2 * p], samples[2 * p + 1])));
                end
            end
        endcase

        @(negedge ice_st_spi_clk);
        cs_drv = 1'b0;
        step_rand();
        gap = 2 + int'(rng_state[1:0]);
        repeat (gap) begin
            @(negedge ice_st_spi_clk);
            check({tx_name[idx], " d_oe idle"}, 32'd0, 32'(d_oe));
        end
        check({tx_name[idx], " led"}, 32'(tx_led[idx]), 32'(led));
    endtask

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge ice_st_spi_clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int i;
        step_rand();
        add_tx("echo_first", ice_msg_pkg::MSG_TYPE_ECHO, rng_state[23:0], 4'h0);
        add_tx("led_set_5", ice_msg_pkg::MSG_TYPE_LED_SET, 24'h000005, 4'h5);
        step_rand();
        add_tx("echo_bit7_clear", 8'h40, rng_state[23:0], 4'h5);
        add_tx("nop", ice_msg_pkg::MSG_TYPE_NOP, 24'hFFFFFA, 4'h5);
        add_tx("unknown_no_resp", 8'h95, 24'h00000C, 4'h5);
        add_tx("led_set_a", ice_msg_pkg::MSG_TYPE_LED_SET, 24'hABCDEA, 4'hA);
        add_tx("readout_first", ice_msg_pkg::MSG_TYPE_READOUT, 24'h000000, 4'hA);
        add_tx("readout_second", ice_msg_pkg::MSG_TYPE_READOUT, 24'h000000, 4'hA);
        step_rand();
        add_tx("echo_after_readout", ice_msg_pkg::MSG_TYPE_ECHO, rng_state[23:0], 4'hA);
        add_tx("led_set_bit7_clear", 8'h01, 24'h000003, 4'h3);
        add_tx("nop_keeps_led", ice_msg_pkg::MSG_TYPE_NOP, 24'h000009, 4'h3);

        // Device deselected for the first 5 clocks
        repeat (5) @(negedge ice_st_spi_clk);
        check("reset d_oe", 32'd0, 32'(d_oe));
        check("reset d_ready", 32'd0, 32'(d_ready));
        check("reset led", 32'd0, 32'(led));

        for (i = 0; i < tx_cnt; i++) begin
            run_tx(i);
        end

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verification/ice_app_top_sva.sv ====
module ice_app_top_sva #(
    parameter int LEVEL_W = $clog2(ice_msg_pkg::FIFO_DEPTH) + 1
) (
    input logic               ice_st_spi_clk,
    input logic               prod_clk,
    input logic               spi_cs,
    input logic               d_oe,
    input logic               w_en,
    input logic               r_en,
    input logic [LEVEL_W-1:0] w_bin,
    input logic [LEVEL_W-1:0] r_bin,
    input logic [LEVEL_W-1:0] r_level
);

    // ==================================================
    // FIFO flow control
    // ==================================================

    // A burst may only begin when a whole chunk of space was free
    a_burst_room: assert property (@(posedge prod_clk) $rose(w_en) |->
            ((w_bin - r_bin) <=
             LEVEL_W'(ice_msg_pkg::FIFO_DEPTH - ice_msg_pkg::CHUNK_LEN)))
        else $error("FIFO burst started without a chunk of free space");

    a_read_empty: assert property (@(posedge ice_st_spi_clk) r_en |-> (r_level != '0))
        else $error("FIFO read while empty");

    // ==================================================
    // Pins
    // ==================================================

    a_oe_release: assert property (@(posedge ice_st_spi_clk) $fell(spi_cs) |=> !d_oe)
        else $error("d_oe still high one clock after spi_cs fell");

endmodule

bind ice_app_top ice_app_top_sva u_ice_app_top_sva (
    .ice_st_spi_clk (ice_st_spi_clk),
    .prod_clk       (prod_clk),
    .spi_cs         (spi_cs),
    .d_oe           (d_oe),
    .w_en           (w_en),
    .r_en           (r_en),
    .w_bin          (u_afifo.w_bin),
    .r_bin          (u_afifo.r_bin),
    .r_level        (u_afifo.r_level)
);

// ==== design/ice_app_top.sv ====
module ice_app_top (
    input  logic       ice_st_spi_clk,
    input  logic       spi_cs,
    input  logic       prod_clk,
    input  logic [7:0] d_in,
    output logic [7:0] d_out,
    output logic       d_oe,
    output logic       d_ready,
    output logic [3:0] led
);
    logic [7:0] d_in_q;
    logic [7:0] d_out_next;
    logic       d_oe_next;
    logic       prod_start_tgl;
    logic       w_en;
    logic [7:0] w_data;
    logic       w_room;
    logic       r_en;
    logic [7:0] r_data;
    logic       r_chunk;

    // Host is told a full chunk is waiting
    assign d_ready = r_chunk;

    spi_pin_regs u_spi_pin_regs (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .d_in           (d_in),
        .d_out_next     (d_out_next),
        .d_oe_next      (d_oe_next),
        .d_in_q         (d_in_q),
        .d_out          (d_out),
        .d_oe           (d_oe)
    );

    // Commands arrive on the low four lines only
    spi_msg_engine u_spi_msg_engine (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .d_in_q         (d_in_q[3:0]),
        .d_out_next     (d_out_next),
        .d_oe_next      (d_oe_next),
        .led            (led),
        .prod_start_tgl (prod_start_tgl),
        .r_data         (r_data),
        .r_chunk        (r_chunk),
        .r_en           (r_en)
    );

    afifo u_afifo (
        .w_clk   (prod_clk),
        .w_en    (w_en),
        .w_data  (w_data),
        .w_room  (w_room),
        .r_clk   (ice_st_spi_clk),
        .r_en    (r_en),
        .r_data  (r_data),
        .r_chunk (r_chunk)
    );

    sample_producer u_sample_producer (
        .prod_clk       (prod_clk),
        .prod_start_tgl (prod_start_tgl),
        .w_room         (w_room),
        .w_en           (w_en),
        .w_data         (w_data)
    );

endmodule

// ==== design/spi_pin_regs.sv ====
module spi_pin_regs (
    input  logic       ice_st_spi_clk,
    input  logic       spi_cs,
    input  logic [7:0] d_in,
    input  logic [7:0] d_out_next,
    input  logic       d_oe_next,
    output logic [7:0] d_in_q,
    output logic [7:0] d_out,
    output logic       d_oe
);

    // Input and output data registers of the I/O cells
    always_ff @(posedge ice_st_spi_clk) begin
        d_in_q <= d_in;
        d_out  <= d_out_next;
    end

    // Releases the bus as soon as the host deselects
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            d_oe <= 1'b0;
        end else begin
            d_oe <= d_oe_next;
        end
    end

endmodule

// ==== spi_engine/spi_msg_engine.sv ====
module spi_msg_engine (
    input  logic       ice_st_spi_clk,
    input  logic       spi_cs,
    input  logic [3:0] d_in_q,
    output logic [7:0] d_out_next,
    output logic       d_oe_next,
    output logic [3:0] led,
    output logic       prod_start_tgl,
    input  logic [7:0] r_data,
    input  logic       r_chunk,
    output logic       r_en
);
    localparam int DIN_CNT_W = $clog2(ice_msg_pkg::MSG_CYCLES + 1);
    localparam int RD_CNT_W  = $clog2(ice_msg_pkg::CHUNK_LEN + 1);
    localparam int RESP_PAD  = ice_msg_pkg::RESP_LEN - ice_msg_pkg::MSG_ARG_LEN;

    typedef enum logic [2:0] {
        ST_MSG_IN,
        ST_DECODE,
        ST_RESP,
        ST_RD_WAIT,
        ST_RD_STREAM,
        ST_IDLE
    } state_t;

    state_t                state;
    logic [DIN_CNT_W-1:0]  din_cnt;
    logic [RD_CNT_W-1:0]   rd_cnt;
    logic                  resp_phase;
    logic                  oe_q;

    logic [ice_msg_pkg::MSG_LEN-1:0]  din_reg;
    logic [ice_msg_pkg::RESP_LEN-1:0] resp_reg;
    logic [15:0]                      dout_reg;
    logic [7:0]                       pair_hi;

    // Kept across transactions
    logic [3:0] led_q   = 4'h0;
    logic       start_q = 1'b0;

    logic [ice_msg_pkg::MSG_TYPE_LEN-1:0] msg_type;
    logic [ice_msg_pkg::MSG_ARG_LEN-1:0]  msg_arg;
    logic                                 rd_last;

    // The host cannot send type bit 7, so it is forced high here
    assign msg_type = {1'b1, din_reg[ice_msg_pkg::MSG_LEN-2 -: ice_msg_pkg::MSG_TYPE_LEN-1]};
    assign msg_arg  = din_reg[ice_msg_pkg::MSG_ARG_LEN-1:0];
    assign rd_last  = (rd_cnt == RD_CNT_W'(ice_msg_pkg::CHUNK_LEN));

    // High nibble of the earlier byte on the upper lines
    assign d_out_next     = {dout_reg[15:12], dout_reg[7:4]};
    assign d_oe_next      = oe_q;
    assign led            = led_q;
    assign prod_start_tgl = start_q;
    assign r_en           = (state == ST_RD_STREAM) && !rd_last;

    // ==================================================
    // Control FSM
    // ==================================================
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            state      <= ST_MSG_IN;
            din_cnt    <= '0;
            rd_cnt     <= '0;
            resp_phase <= 1'b0;
            oe_q       <= 1'b0;
        end else begin
            oe_q <= 1'b0;
            case (state)
                // One extra count covers the input pin register
                ST_MSG_IN: begin
                    din_cnt <= din_cnt + DIN_CNT_W'(1);
                    if (din_cnt == DIN_CNT_W'(ice_msg_pkg::MSG_CYCLES)) begin
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    rd_cnt     <= '0;
                    resp_phase <= 1'b0;
                    case (msg_type)
                        ice_msg_pkg::MSG_TYPE_ECHO:    state <= ST_RESP;
                        ice_msg_pkg::MSG_TYPE_READOUT: state <= ST_RD_WAIT;
                        ice_msg_pkg::MSG_TYPE_LED_SET,
                        ice_msg_pkg::MSG_TYPE_NOP:     state <= ST_IDLE;
                        default: begin
                            state <= msg_type[ice_msg_pkg::MSG_TYPE_RESP_BIT] ?
                                     ST_RESP : ST_IDLE;
                        end
                    endcase
                end
                // Bus stays driven until the host deselects
                ST_RESP: begin
                    oe_q       <= 1'b1;
                    resp_phase <= !resp_phase;
                end
                ST_RD_WAIT: begin
                    if (r_chunk) begin
                        state <= ST_RD_STREAM;
                    end
                end
                ST_RD_STREAM: begin
                    rd_cnt <= rd_cnt + RD_CNT_W'(1);
                    oe_q   <= (rd_cnt != '0);
                    if (rd_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: ;
            endcase
        end
    end

    // ==================================================
    // Data path
    // ==================================================
    always_ff @(posedge ice_st_spi_clk) begin
        dout_reg <= dout_reg << 4;
        if (state == ST_MSG_IN) begin
            din_reg <= {din_reg[ice_msg_pkg::MSG_LEN-5:0], d_in_q};
        end

        case (state)
            ST_DECODE: begin
                resp_reg <= '0;
                if (msg_type == ice_msg_pkg::MSG_TYPE_ECHO) begin
                    resp_reg <= {msg_arg, RESP_PAD'(0)};
                end
            end
            // Upper 16 bits go out first
            ST_RESP: begin
                if (!resp_phase) begin
                    dout_reg <= resp_reg[ice_msg_pkg::RESP_LEN-1 -: 16];
                    resp_reg <= resp_reg << 16;
                end
            end
            // Even count holds the earlier byte, odd count completes the pair
            ST_RD_STREAM: begin
                if (r_en) begin
                    if (rd_cnt[0]) begin
                        dout_reg <= {pair_hi, r_data};
                    end else begin
                        pair_hi <= r_data;
                    end
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge ice_st_spi_clk) begin
        if (state == ST_DECODE) begin
            if (msg_type == ice_msg_pkg::MSG_TYPE_LED_SET) begin
                led_q <= msg_arg[3:0];
            end
            // Producer runs forever once started, so this flips only once
            if (msg_type == ice_msg_pkg::MSG_TYPE_READOUT && !start_q) begin
                start_q <= !start_q;
            end
        end
    end

endmodule

// ==== design/sample_producer.sv ====
module sample_producer (
    input  logic       prod_clk,
    input  logic       prod_start_tgl,
    input  logic       w_room,
    output logic       w_en,
    output logic [7:0] w_data
);
    localparam int CNT_W = $clog2(ice_msg_pkg::CHUNK_LEN);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(ice_msg_pkg::CHUNK_LEN - 1);

    typedef enum logic [1:0] {
        ST_OFF,
        ST_WAIT,
        ST_BURST
    } state_t;

    state_t           state    = ST_OFF;
    logic [2:0]       tgl_sync = '0;
    logic [CNT_W-1:0] byte_cnt = '0;
    logic             w_en_q   = 1'b0;
    logic [7:0]       w_data_q = '0;
    logic             start_pulse;
    logic             burst_go;

    // Two synchronizer flops, the third one only for edge detection
    assign start_pulse = tgl_sync[2] ^ tgl_sync[1];

    // Room is only trusted once no write is in flight
    assign burst_go = w_room && !w_en_q &&
                      ((state == ST_WAIT) || (state == ST_OFF && start_pulse));

    assign w_en   = w_en_q;
    assign w_data = w_data_q;

    always_ff @(posedge prod_clk) begin
        tgl_sync <= {tgl_sync[1:0], prod_start_tgl};
        w_en_q   <= 1'b0;

        case (state)
            ST_OFF: begin
                if (start_pulse) begin
                    state <= ST_WAIT;
                end
            end
            ST_BURST: begin
                w_en_q   <= 1'b1;
                w_data_q <= w_data_q - 8'd1;
                byte_cnt <= byte_cnt + CNT_W'(1);
                if (byte_cnt == LAST_BYTE) begin
                    state <= ST_WAIT;
                end
            end
            default: ;
        endcase

        // First byte of a burst, counting down from 8'hFF
        if (burst_go) begin
            w_en_q   <= 1'b1;
            w_data_q <= 8'hFF;
            byte_cnt <= CNT_W'(1);
            state    <= ST_BURST;
        end
    end

endmodule

// ==== afifo/afifo.sv ====
module afifo #(
    parameter int FIFO_DEPTH = ice_msg_pkg::FIFO_DEPTH
) (
    input  logic       w_clk,
    input  logic       w_en,
    input  logic [7:0] w_data,
    output logic       w_room,
    input  logic       r_clk,
    input  logic       r_en,
    output logic [7:0] r_data,
    output logic       r_chunk
);
    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] ROOM_MAX_LEVEL = (AW+1)'(FIFO_DEPTH - ice_msg_pkg::CHUNK_LEN);
    localparam logic [AW:0] CHUNK_LEVEL    = (AW+1)'(ice_msg_pkg::CHUNK_LEN);

    logic [7:0] mem [FIFO_DEPTH];

    function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
        logic [AW:0] b;
        b[AW] = g[AW];
        for (int i = AW - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // ==================================================
    // Write domain
    // ==================================================
    logic [AW:0] w_bin     = '0;
    logic [AW:0] w_gray    = '0;
    logic [AW:0] r_gray_s1 = '0;
    logic [AW:0] r_gray_s2 = '0;
    logic        w_room_q  = 1'b0;
    logic [AW:0] w_bin_next;
    logic [AW:0] w_level_next;

    assign w_bin_next   = w_bin + (AW+1)'(w_en);
    assign w_level_next = w_bin_next - gray2bin(r_gray_s2);
    assign w_room       = w_room_q;

    always_ff @(posedge w_clk) begin
        if (w_en) begin
            mem[w_bin[AW-1:0]] <= w_data;
        end
    end

    always_ff @(posedge w_clk) begin
        w_bin     <= w_bin_next;
        w_gray    <= w_bin_next ^ (w_bin_next >> 1);
        r_gray_s1 <= r_gray;
        r_gray_s2 <= r_gray_s1;
        // Counts the write in flight, so a full chunk of space is really free
        w_room_q  <= (w_level_next <= ROOM_MAX_LEVEL);
    end

    // ==================================================
    // Read domain
    // ==================================================
    logic [AW:0] r_bin     = '0;
    logic [AW:0] r_gray    = '0;
    logic [AW:0] w_gray_s1 = '0;
    logic [AW:0] w_gray_s2 = '0;
    logic        r_chunk_q = 1'b0;
    logic [AW:0] r_bin_next;
    logic [AW:0] r_level;
    logic [AW:0] r_level_next;

    assign r_bin_next   = r_bin + (AW+1)'(r_en);
    assign r_level      = gray2bin(w_gray_s2) - r_bin;
    assign r_level_next = r_level - (AW+1)'(r_en);
    // Head of the queue, valid whenever r_level is nonzero
    assign r_data       = mem[r_bin[AW-1:0]];
    assign r_chunk      = r_chunk_q;

    always_ff @(posedge r_clk) begin
        r_bin     <= r_bin_next;
        r_gray    <= r_bin_next ^ (r_bin_next >> 1);
        w_gray_s1 <= w_gray;
        w_gray_s2 <= w_gray_s1;
        r_chunk_q <= (r_level_next >= CHUNK_LEVEL);
    end

endmodule

// ==== common/ice_msg_pkg.sv ====
package ice_msg_pkg;

    // ==================================================
    // Command message layout
    // ==================================================

    // Type byte on top, argument below it
    localparam int MSG_LEN      = 32;
    localparam int MSG_TYPE_LEN = 8;
    localparam int MSG_ARG_LEN  = MSG_LEN - MSG_TYPE_LEN;

    // One dummy byte, then the message, a nibble per clock
    localparam int MSG_CYCLES = 2 + MSG_LEN / 4;

    // ==================================================
    // Message types
    // ==================================================

    localparam logic [MSG_TYPE_LEN-1:0] MSG_TYPE_ECHO    = 8'hC0;
    localparam logic [MSG_TYPE_LEN-1:0] MSG_TYPE_LED_SET = 8'h81;
    localparam logic [MSG_TYPE_LEN-1:0] MSG_TYPE_READOUT = 8'h82;
    localparam logic [MSG_TYPE_LEN-1:0] MSG_TYPE_NOP     = 8'h83;

    // Set in the type when the host expects a response
    localparam int MSG_TYPE_RESP_BIT = 6;

    // ==================================================
    // Response and readout sizes
    // ==================================================

    // Echo puts the argument in the upper 24 bits
    localparam int RESP_LEN = 32;

    // Bytes per readout chunk, also the producer burst length
    localparam int CHUNK_LEN = 256;

    // Needs to be a power of two, at least two chunks
    localparam int FIFO_DEPTH = 512;

endpackage
